// ==== noc_pkg.sv ====
// shared definitions for the mesh node
// packet layout, mesh constants and the port direction enum

`default_nettype none

package noc_pkg;

    // ========================================
    // mesh and packet sizes
    // ========================================
    localparam int NUM_PORTS = 5;
    localparam int COORD_W   = 3;               // one mesh coordinate
    localparam int ID_W      = 2 * COORD_W;     // y in the high half, x in the low half
    localparam int PKT_W     = 23;

    // ========================================
    // packet field positions, msb first
    // ========================================
    localparam int TYPE_HI = 22;                // type, carried but not decoded
    localparam int TYPE_LO = 21;
    localparam int SRC_HI  = 20;                // source id
    localparam int SRC_LO  = 15;
    localparam int TGT_HI  = 14;                // target id
    localparam int TGT_LO  = 9;
    localparam int QOS_POS = 8;
    localparam int DATA_HI = 7;                 // payload byte
    localparam int DATA_LO = 0;

    // port direction, also the index of every per-port array
    typedef enum logic [2:0] {
        DIR_N = 3'd0,                           // larger y
        DIR_W = 3'd1,
        DIR_S = 3'd2,
        DIR_E = 3'd3,                           // larger x
        DIR_L = 3'd4                            // local core
    } port_dir_e;

endpackage

`default_nettype wire

// ==== credit_counter.sv ====
// downstream credit count for one output

`timescale 1ns/1ps
`default_nettype none

module credit_counter #(
    parameter int DOWN_CREDITS = 4
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic send_i,
    input  logic credit_i,
    output logic avail_o
);

    localparam int CNT_W = $clog2(DOWN_CREDITS + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count <= CNT_W'(DOWN_CREDITS);  // receiver buffer starts empty
        end else begin
            case ({send_i, credit_i})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    assign avail_o = (count != '0);

endmodule

`default_nettype wire

// ==== qos_arbiter.sv ====
// output arbiter
// qos requesters win first, round-robin among equals

`timescale 1ns/1ps
`default_nettype none

module qos_arbiter (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [noc_pkg::NUM_PORTS-1:0] req_i,
    input  logic [noc_pkg::NUM_PORTS-1:0] qos_i,
    input  logic                          allow_i,
    output logic [noc_pkg::NUM_PORTS-1:0] gnt_o
);

    localparam int IDX_W = $clog2(noc_pkg::NUM_PORTS);

    logic [noc_pkg::NUM_PORTS-1:0] qos_req;
    logic [noc_pkg::NUM_PORTS-1:0] cand;
    logic [IDX_W-1:0]              rr_ptr;    // first index searched
    logic [IDX_W-1:0]              win_idx;
    logic                          found;
    logic                          grant;

    // index arithmetic modulo the port count
    function automatic logic [IDX_W-1:0] wrap_add(
        input logic [IDX_W-1:0] base,
        input int unsigned      step
    );
        int unsigned sum;
        sum = int'(base) + step;
        if (sum >= noc_pkg::NUM_PORTS) begin
            sum = sum - noc_pkg::NUM_PORTS;
        end
        return IDX_W'(sum);
    endfunction

    // only qos requesters compete when any is present
    assign qos_req = req_i & qos_i;
    assign cand    = (|qos_req) ? qos_req : req_i;

    always_comb begin
        found   = 1'b0;
        win_idx = rr_ptr;
        for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
            if (!found && cand[wrap_add(rr_ptr, i)]) begin
                found   = 1'b1;
                win_idx = wrap_add(rr_ptr, i);
            end
        end
    end

    assign grant = allow_i && found;
    assign gnt_o = grant ? (noc_pkg::NUM_PORTS'(1) << win_idx) : '0;

    // pointer moves past the winner, only on a real grant
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rr_ptr <= '0;       // north searched first
        end else if (grant) begin
            rr_ptr <= wrap_add(win_idx, 1);
        end
    end

endmodule

`default_nettype wire

// ==== input_port.sv ====
// mesh input port
// packet buffer with an XY route for the head and credit return upstream

`timescale 1ns/1ps
`default_nettype none

module input_port #(
    parameter int NODE_X     = 0,
    parameter int NODE_Y     = 0,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        vld_i,
    input  logic [noc_pkg::PKT_W-1:0]   pkt_i,
    output logic                        credit_o,
    input  logic                        pop_i,
    output logic [noc_pkg::NUM_PORTS-1:0] req_o,
    output logic [noc_pkg::PKT_W-1:0]   head_pkt_o,
    output logic                        head_qos_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [noc_pkg::COORD_W-1:0] MY_X = NODE_X[noc_pkg::COORD_W-1:0];
    localparam logic [noc_pkg::COORD_W-1:0] MY_Y = NODE_Y[noc_pkg::COORD_W-1:0];

    logic [noc_pkg::PKT_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;
    logic                      empty;

    logic [noc_pkg::ID_W-1:0]    tgt_id;
    logic [noc_pkg::COORD_W-1:0] tgt_x;
    logic [noc_pkg::COORD_W-1:0] tgt_y;
    noc_pkg::port_dir_e          route;

    // ========================================
    // buffer
    // ========================================
    always_ff @(posedge clk) begin
        if (vld_i) begin
            mem[wr_ptr] <= pkt_i;   // sender holds a credit, so never full
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (vld_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({vld_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_o <= pop_i;      // one slot freed, tell upstream
        end
    end

    assign empty      = (count == '0);
    assign head_pkt_o = mem[rd_ptr];
    assign head_qos_o = head_pkt_o[noc_pkg::QOS_POS];

    // ========================================
    // XY route, x settled first
    // ========================================
    assign tgt_id = head_pkt_o[noc_pkg::TGT_HI:noc_pkg::TGT_LO];
    assign tgt_x  = tgt_id[noc_pkg::COORD_W-1:0];
    assign tgt_y  = tgt_id[noc_pkg::ID_W-1:noc_pkg::COORD_W];

    always_comb begin
        if (tgt_x > MY_X) begin
            route = noc_pkg::DIR_E;
        end else if (tgt_x < MY_X) begin
            route = noc_pkg::DIR_W;
        end else if (tgt_y > MY_Y) begin
            route = noc_pkg::DIR_N;
        end else if (tgt_y < MY_Y) begin
            route = noc_pkg::DIR_S;
        end else begin
            route = noc_pkg::DIR_L;     // arrived
        end
    end

    // one-hot request toward the chosen output
    assign req_o = empty ? '0 : (noc_pkg::NUM_PORTS'(1) << route);

endmodule

`default_nettype wire

// ==== output_port.sv ====
// mesh output port
// arbitrates the inputs, selects the winner and registers it toward the link

`timescale 1ns/1ps
`default_nettype none

module output_port #(
    parameter int DOWN_CREDITS = 4
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic [noc_pkg::NUM_PORTS-1:0] req_i,
    input  logic [noc_pkg::NUM_PORTS-1:0] qos_i,
    input  logic [noc_pkg::PKT_W-1:0]     pkt_i [noc_pkg::NUM_PORTS],
    output logic [noc_pkg::NUM_PORTS-1:0] gnt_o,
    input  logic                          credit_i,
    output logic                          vld_o,
    output logic [noc_pkg::PKT_W-1:0]     pkt_o
);

    logic                      avail;
    logic                      send;
    logic [noc_pkg::PKT_W-1:0] sel_pkt;

    // ========================================
    // arbitration and credits
    // ========================================
    qos_arbiter u_arb (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .qos_i   (qos_i),
        .allow_i (avail),       // no credit, no grant
        .gnt_o   (gnt_o)
    );

    assign send = |gnt_o;

    credit_counter #(
        .DOWN_CREDITS (DOWN_CREDITS)
    ) u_credit (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .send_i   (send),
        .credit_i (credit_i),
        .avail_o  (avail)
    );

    // grant is one-hot, so an and-or mux is enough
    always_comb begin
        sel_pkt = '0;
        for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
            sel_pkt = sel_pkt | (pkt_i[i] & {noc_pkg::PKT_W{gnt_o[i]}});
        end
    end

    // ========================================
    // output register
    // ========================================
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_o <= 1'b0;
        end else begin
            vld_o <= send;      // single cycle pulse per packet
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            pkt_o <= sel_pkt;
        end
    end

endmodule

`default_nettype wire

// ==== mesh_node.sv ====
// one node of the 2D mesh
// five credit-flow input buffers, XY routing and a qos crossbar to five outputs

`timescale 1ns/1ps
`default_nettype none

module mesh_node #(
    parameter int NODE_X       = 0,
    parameter int NODE_Y       = 0,
    parameter int FIFO_DEPTH   = 4,
    parameter int DOWN_CREDITS = 4
) (
    input  logic                      clk,
    input  logic                      rst_n_i,
    // upstream side, indexed by port_dir_e
    input  logic                      in_vld_i     [noc_pkg::NUM_PORTS],
    input  logic [noc_pkg::PKT_W-1:0] in_pkt_i     [noc_pkg::NUM_PORTS],
    output logic                      in_credit_o  [noc_pkg::NUM_PORTS],
    // downstream side
    output logic                      out_vld_o    [noc_pkg::NUM_PORTS],
    output logic [noc_pkg::PKT_W-1:0] out_pkt_o    [noc_pkg::NUM_PORTS],
    input  logic                      out_credit_i [noc_pkg::NUM_PORTS]
);

    logic [noc_pkg::NUM_PORTS-1:0] req_by_in  [noc_pkg::NUM_PORTS];   // [input][output]
    logic [noc_pkg::NUM_PORTS-1:0] req_by_out [noc_pkg::NUM_PORTS];   // [output][input]
    logic [noc_pkg::NUM_PORTS-1:0] gnt_by_out [noc_pkg::NUM_PORTS];   // [output][input]
    logic [noc_pkg::NUM_PORTS-1:0] gnt_by_in  [noc_pkg::NUM_PORTS];   // [input][output]
    logic [noc_pkg::PKT_W-1:0]     head_pkt   [noc_pkg::NUM_PORTS];
    logic [noc_pkg::NUM_PORTS-1:0] head_qos;

    // ========================================
    // crossbar transpose
    // ========================================
    for (genvar i = 0; i < noc_pkg::NUM_PORTS; i++) begin : g_xbar_in
        for (genvar d = 0; d < noc_pkg::NUM_PORTS; d++) begin : g_xbar_out
            assign req_by_out[d][i] = req_by_in[i][d];
            assign gnt_by_in[i][d]  = gnt_by_out[d][i];
        end
    end

    // ========================================
    // ports, one per direction
    // ========================================
    for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++) begin : g_port
        input_port #(
            .NODE_X     (NODE_X),
            .NODE_Y     (NODE_Y),
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_in (
            .clk        (clk),
            .rst_n_i    (rst_n_i),
            .vld_i      (in_vld_i[p]),
            .pkt_i      (in_pkt_i[p]),
            .credit_o   (in_credit_o[p]),
            .pop_i      (|gnt_by_in[p]),    // at most one output grants
            .req_o      (req_by_in[p]),
            .head_pkt_o (head_pkt[p]),
            .head_qos_o (head_qos[p])
        );

        output_port #(
            .DOWN_CREDITS (DOWN_CREDITS)
        ) u_out (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .req_i    (req_by_out[p]),
            .qos_i    (head_qos),
            .pkt_i    (head_pkt),
            .gnt_o    (gnt_by_out[p]),
            .credit_i (out_credit_i[p]),
            .vld_o    (out_vld_o[p]),
            .pkt_o    (out_pkt_o[p])
        );
    end

endmodule

`default_nettype wire

// ==== tb_mesh_node.sv ====
// testbench for the mesh node at (3,4)
// directed tests with credit models for the upstream and downstream neighbours

`timescale 1ns/1ps
`default_nettype none

module tb_mesh_node;

    localparam int NP           = noc_pkg::NUM_PORTS;
    localparam int PW           = noc_pkg::PKT_W;
    localparam int NODE_X       = 3;
    localparam int NODE_Y       = 4;
    localparam int FIFO_DEPTH   = 4;
    localparam int DOWN_CREDITS = 4;
    localparam int OUT_WAIT     = 50;                           // cycles allowed per packet
    localparam int TEST_CYCLES  = 200;                          // six tests and their resets
    localparam int WATCHDOG_NS  = (TEST_CYCLES + 300) * 10;

    logic          clk;
    logic          rst_n;
    logic          in_vld     [NP];
    logic [PW-1:0] in_pkt     [NP];
    logic          in_credit  [NP];
    logic          out_vld    [NP];
    logic [PW-1:0] out_pkt    [NP];
    logic          out_credit [NP];

    int            sender_cred [NP];    // credits held by each upstream sender
    int            acc_cnt     [NP];
    int            ret_cnt     [NP];
    int            pend        [NP];    // downstream credits queued for return
    int            held        [NP];
    bit            auto_ret    [NP];
    int            cyc;
    int            seed;
    logic [PW+2:0] got_q [$];           // {port, packet} in arrival order
    int            got_cyc [$];
    logic [PW-1:0] burst [NP][3*FIFO_DEPTH];

    mesh_node #(
        .NODE_X       (NODE_X),
        .NODE_Y       (NODE_Y),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .DOWN_CREDITS (DOWN_CREDITS)
    ) UUT (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .in_vld_i     (in_vld),
        .in_pkt_i     (in_pkt),
        .in_credit_o  (in_credit),
        .out_vld_o    (out_vld),
        .out_pkt_o    (out_pkt),
        .out_credit_i (out_credit)
    );

    always #5 clk = ~clk;
    always @(posedge clk) cyc++;

    // ========================================
    // neighbour models
    // ========================================
    always @(negedge clk) begin
        for (int d = 0; d < NP; d++) begin
            if (out_vld[d]) begin
                got_q.push_back({3'(d), out_pkt[d]});
                got_cyc.push_back(cyc);
                if (auto_ret[d]) begin
                    pend[d]++;
                end else begin
                    held[d]++;                  // kept until the test frees it
                end
            end
            if (in_credit[d]) begin
                sender_cred[d]++;
                ret_cnt[d]++;
            end
            assert (ret_cnt[d] <= acc_cnt[d])
                else report_mismatch($sformatf("input %0d credit count out of range", d));
        end
    end

    always @(posedge clk) begin
        #2;
        for (int d = 0; d < NP; d++) begin
            out_credit[d] = (pend[d] > 0);      // one pulse per queued credit
            if (pend[d] > 0) begin
                pend[d]--;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_problem("watchdog expired before the tests finished");
    end

    // ========================================
    // helpers
    // ========================================
    task automatic end_with_failure();
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string what);
        $display("Fail at %0d ns: %s", $time, what);
        end_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        end_with_failure();
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        for (int d = 0; d < NP; d++) begin
            in_vld[d]      = 1'b0;
            sender_cred[d] = FIFO_DEPTH;
            acc_cnt[d]     = 0;
            ret_cnt[d]     = 0;
            pend[d]        = 0;
            held[d]        = 0;
            auto_ret[d]    = 1'b1;
        end
        got_q.delete();
        got_cyc.delete();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    function automatic logic [PW-1:0] make_pkt(input int tx, input int ty, input bit qos);
        logic [PW-1:0] p;
        int            rnd;
        rnd = $random(seed);
        p = '0;
        p[noc_pkg::TYPE_HI:noc_pkg::TYPE_LO] = 2'b01;
        p[noc_pkg::SRC_HI:noc_pkg::SRC_LO]   = 6'h21;  // carried only
        p[noc_pkg::TGT_HI:noc_pkg::TGT_LO]   = {ty[2:0], tx[2:0]};
        p[noc_pkg::QOS_POS]                  = qos;
        p[noc_pkg::DATA_HI:noc_pkg::DATA_LO] = rnd[7:0];
        return p;
    endfunction

    // x first, north is larger y
    function automatic int route_of(input int tx, input int ty);
        if (tx > NODE_X) return noc_pkg::DIR_E;
        if (tx < NODE_X) return noc_pkg::DIR_W;
        if (ty > NODE_Y) return noc_pkg::DIR_N;
        if (ty < NODE_Y) return noc_pkg::DIR_S;
        return noc_pkg::DIR_L;
    endfunction

    // called at the drive point, returns at the next one
    task automatic send_pkt(input int port, input logic [PW-1:0] pkt, output int drv_cyc);
        while (sender_cred[port] == 0) begin
            wait_cycles(1);
        end
        in_vld[port] = 1'b1;
        in_pkt[port] = pkt;
        sender_cred[port]--;
        acc_cnt[port]++;
        drv_cyc = cyc;
        wait_cycles(1);
        in_vld[port] = 1'b0;
    endtask

    task automatic send_burst(input int port, input int n);
        int dc;
        for (int k = 0; k < n; k++) begin
            send_pkt(port, burst[port][k], dc);
        end
    endtask

    task automatic wait_out(output int port, output logic [PW-1:0] pkt, output int at_cyc);
        logic [PW+2:0] entry;
        int            n;
        n = 0;
        while (got_q.size() == 0 && n < OUT_WAIT) begin
            wait_cycles(1);
            n++;
        end
        if (got_q.size() == 0) begin
            report_problem("no packet left the node within the time allowed");
        end else begin
            entry  = got_q.pop_front();
            port   = int'(entry[PW+2:PW]);
            pkt    = entry[PW-1:0];
            at_cyc = got_cyc.pop_front();
        end
    endtask

    task automatic expect_pkt(input int port, input logic [PW-1:0] pkt);
        int            got_port;
        logic [PW-1:0] got_pkt;
        int            at_cyc;
        wait_out(got_port, got_pkt, at_cyc);
        assert (got_port == port && got_pkt == pkt)
            else report_mismatch($sformatf("expected %h on port %0d, got %h on port %0d",
                                           pkt, port, got_pkt, got_port));
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic xy_routing();
        // five from local, then north, west, south, east and north again
        int            src [10] = '{4, 4, 4, 4, 4, 0, 1, 2, 3, 0};
        int            tx  [10] = '{5, 1, 3, 3, 3, 3, 6, 3, 0, 3};
        int            ty  [10] = '{4, 4, 6, 1, 4, 0, 2, 7, 4, 4};
        logic [PW-1:0] p;
        int            dc;
        apply_reset();
        for (int k = 0; k < 10; k++) begin
            p = make_pkt(tx[k], ty[k], 1'b0);
            send_pkt(src[k], p, dc);
            expect_pkt(route_of(tx[k], ty[k]), p);
        end
    endtask

    task automatic lone_packet_latency();
        logic [PW-1:0] p;
        logic [PW-1:0] got_pkt;
        int            dc;
        int            got_port;
        int            at_cyc;
        apply_reset();
        p = make_pkt(5, 4, 1'b0);
        send_pkt(noc_pkg::DIR_L, p, dc);
        wait_out(got_port, got_pkt, at_cyc);
        assert (at_cyc - dc == 2 && got_pkt == p && got_port == noc_pkg::DIR_E)
            else report_mismatch($sformatf("latency %0d cycles on port %0d, expected 2 on %0d",
                                           at_cyc - dc, got_port, noc_pkg::DIR_E));
    endtask

    task automatic qos_priority();
        logic [PW-1:0] p_plain;
        logic [PW-1:0] p_qos;
        int            d0;
        int            d1;
        apply_reset();
        p_plain = make_pkt(3, 4, 1'b0);
        p_qos   = make_pkt(3, 4, 1'b1);
        fork
            send_pkt(noc_pkg::DIR_N, p_plain, d0);  // north is first in round-robin
            send_pkt(noc_pkg::DIR_E, p_qos, d1);
        join
        expect_pkt(noc_pkg::DIR_L, p_qos);
        expect_pkt(noc_pkg::DIR_L, p_plain);
    endtask

    task automatic round_robin_order();
        apply_reset();
        for (int s = 0; s < 3; s++) begin
            for (int k = 0; k < 3; k++) begin
                burst[s][k] = make_pkt(3, 4, 1'b0);
            end
        end
        fork
            send_burst(noc_pkg::DIR_N, 3);
            send_burst(noc_pkg::DIR_W, 3);
            send_burst(noc_pkg::DIR_S, 3);
        join
        // pointer starts at north and moves past each winner
        for (int k = 0; k < 3; k++) begin
            for (int s = 0; s < 3; s++) begin
                expect_pkt(noc_pkg::DIR_L, burst[s][k]);
            end
        end
    endtask

    task automatic output_credit_stall();
        apply_reset();
        auto_ret[noc_pkg::DIR_E] = 1'b0;
        for (int k = 0; k < DOWN_CREDITS + 2; k++) begin
            burst[noc_pkg::DIR_L][k] = make_pkt(6, k, 1'b0);
        end
        send_burst(noc_pkg::DIR_L, DOWN_CREDITS + 2);
        wait_cycles(10);
        assert (got_q.size() == DOWN_CREDITS)
            else report_mismatch($sformatf("%0d packets left on %0d credits",
                                           got_q.size(), DOWN_CREDITS));
        for (int k = 0; k < DOWN_CREDITS + 2; k++) begin
            if (k >= DOWN_CREDITS) begin
                pend[noc_pkg::DIR_E]++;         // release exactly one more
            end
            expect_pkt(noc_pkg::DIR_E, burst[noc_pkg::DIR_L][k]);
            if (k >= DOWN_CREDITS) begin
                wait_cycles(5);
                assert (got_q.size() == 0)
                    else report_mismatch("packet sent without a downstream credit");
            end
        end
    endtask

    task automatic input_credit_return();
        apply_reset();
        auto_ret[noc_pkg::DIR_W] = 1'b0;
        for (int k = 0; k < 3 * FIFO_DEPTH; k++) begin
            burst[noc_pkg::DIR_E][k] = make_pkt(1, k % 8, 1'b0);
        end
        fork
            send_burst(noc_pkg::DIR_E, 3 * FIFO_DEPTH);
            begin
                wait_cycles(20);
                assert (sender_cred[noc_pkg::DIR_E] == 0)
                    else report_mismatch("sender should stall with the buffer full");
                auto_ret[noc_pkg::DIR_W] = 1'b1;
                pend[noc_pkg::DIR_W] += held[noc_pkg::DIR_W];
                held[noc_pkg::DIR_W] = 0;
            end
        join
        for (int k = 0; k < 3 * FIFO_DEPTH; k++) begin
            expect_pkt(noc_pkg::DIR_W, burst[noc_pkg::DIR_E][k]);
        end
        wait_cycles(5);
        assert (ret_cnt[noc_pkg::DIR_E] == 3 * FIFO_DEPTH
                && sender_cred[noc_pkg::DIR_E] == FIFO_DEPTH)
            else report_mismatch($sformatf("%0d credits returned for %0d packets",
                                           ret_cnt[noc_pkg::DIR_E], 3 * FIFO_DEPTH));
    endtask

    initial begin
        seed = 30;
        clk  = 1'b0;
        cyc  = 0;
        for (int d = 0; d < NP; d++) begin
            in_vld[d]     = 1'b0;
            in_pkt[d]     = '0;
            out_credit[d] = 1'b0;
        end
        xy_routing();
        lone_packet_latency();
        qos_priority();
        round_robin_order();
        output_credit_stall();
        input_credit_return();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
noc_pkg.sv
credit_counter.sv
qos_arbiter.sv
input_port.sv
output_port.sv
mesh_node.sv
tb_mesh_node.sv
